// ==== hdl/j4_pkg.sv ====
`default_nettype none

package j4_pkg;

  localparam int word_width = 16;  // data word, default for WIDTH
  localparam int num_slots  = 4;   // hardware threads sharing the pipe

  typedef logic [15:0] insn_t;
  typedef logic [12:0] pc_t;       // word address into code ram
  typedef logic [1:0]  slot_t;     // thread number, steps in gray order

  // class codes from insn[15:13]
  // every word with bit 15 set is a literal, so cls_lit stands for 1xx
  localparam logic [2:0] cls_jmp  = 3'b000;
  localparam logic [2:0] cls_zbr  = 3'b001;  // 0branch
  localparam logic [2:0] cls_call = 3'b010;
  localparam logic [2:0] cls_alu  = 3'b011;
  localparam logic [2:0] cls_lit  = 3'b100;

  // st0 operations, insn[11:8] of an alu word
  localparam logic [3:0] op_t     = 4'd0;
  localparam logic [3:0] op_n     = 4'd1;
  localparam logic [3:0] op_add   = 4'd2;
  localparam logic [3:0] op_and   = 4'd3;
  localparam logic [3:0] op_or    = 4'd4;
  localparam logic [3:0] op_xor   = 4'd5;
  localparam logic [3:0] op_inv   = 4'd6;
  localparam logic [3:0] op_eq    = 4'd7;
  localparam logic [3:0] op_lt    = 4'd8;   // signed
  localparam logic [3:0] op_sra   = 4'd9;
  localparam logic [3:0] op_shl   = 4'd10;
  localparam logic [3:0] op_r     = 4'd11;
  localparam logic [3:0] op_mem   = 4'd12;  // data ram read, one turn late
  localparam logic [3:0] op_io    = 4'd13;  // io read, one turn late
  localparam logic [3:0] op_depth = 4'd14;
  localparam logic [3:0] op_ult   = 4'd15;

  // side functions, insn[6:4] of an alu word
  localparam logic [2:0] fn_t_n   = 3'd1;
  localparam logic [2:0] fn_t_r   = 3'd2;
  localparam logic [2:0] fn_mem_w = 3'd3;
  localparam logic [2:0] fn_io_w  = 3'd4;
  localparam logic [2:0] fn_io_r  = 3'd5;

  localparam int ret_bit = 7;  // alu word returns through rst0

  // next pc source, decode to core
  localparam logic [1:0] pc_sel_inc    = 2'd0;
  localparam logic [1:0] pc_sel_target = 2'd1;
  localparam logic [1:0] pc_sel_ret    = 2'd2;
  localparam logic [1:0] pc_sel_zero   = 2'd3;

  function automatic logic [2:0] insn_class(insn_t insn);
    return insn[15] ? cls_lit : insn[15:13];
  endfunction

  // 00 -> 01 -> 11 -> 10 -> 00
  function automatic slot_t gray_next(slot_t s);
    return {s[0], ~s[1]};
  endfunction

endpackage

`default_nettype wire

// ==== hdl/j4_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module j4_decode (
  input  j4_pkg::insn_t insn,             // instruction of the slot now executing
  input  logic          reboot,           // slot restarts at 0 this turn
  input  logic          st0_zero,         // flag for 0branch
  output logic          dstk_we,
  output logic          rstk_we,
  output logic [1:0]    dsp_delta,        // 01 push, 11 pop, 10 pop two
  output logic [1:0]    rsp_delta,
  output logic [1:0]    pc_sel,
  output logic          push_return_addr, // rstack takes pc+1 rather than st0
  output logic          mem_wr,
  output logic          io_wr,
  output logic          io_rd
);
  import j4_pkg::*;

  logic [2:0] cls;
  logic [2:0] fn;

  assign cls = insn_class(insn);
  assign fn  = insn[6:4];
  assign push_return_addr = (cls == cls_call);  // only read when rstk_we is set

  always_comb begin
    dstk_we   = 1'b0;
    rstk_we   = 1'b0;
    dsp_delta = 2'b00;
    rsp_delta = 2'b00;
    pc_sel    = pc_sel_inc;
    mem_wr    = 1'b0;
    io_wr     = 1'b0;
    io_rd     = 1'b0;
    if (reboot) begin
      pc_sel = pc_sel_zero;  // whole turn is a nop that lands at 0
    end else begin
      case (cls)
        cls_lit: begin
          dstk_we   = 1'b1;  // old st0 goes under the literal
          dsp_delta = 2'b01;
        end
        cls_jmp: pc_sel = pc_sel_target;
        cls_zbr: begin
          dsp_delta = 2'b11;  // flag consumed, taken or not
          if (st0_zero)
            pc_sel = pc_sel_target;
        end
        cls_call: begin
          rstk_we   = 1'b1;  // return address pushed
          rsp_delta = 2'b01;
          pc_sel    = pc_sel_target;
        end
        cls_alu: begin
          dstk_we   = (fn == fn_t_n);
          dsp_delta = insn[1:0];
          rstk_we   = (fn == fn_t_r);
          rsp_delta = insn[3:2];
          if (insn[ret_bit])
            pc_sel = pc_sel_ret;
          mem_wr = (fn == fn_mem_w);  // st1 stored at st0
          io_wr  = (fn == fn_io_w);
          io_rd  = (fn == fn_io_r);   // data comes back on the next turn
        end
        default: ;  // no other codes come out of insn_class
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/j4_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module j4_alu #(
  parameter int WIDTH = j4_pkg::word_width
) (
  input  j4_pkg::insn_t    insn,
  input  logic [WIDTH-1:0] st0,
  input  logic [WIDTH-1:0] st1,
  input  logic [WIDTH-1:0] rst0,
  input  logic [WIDTH-1:0] rd_data,  // io or ram word, already lined up with this slot
  input  logic [4:0]       dsp,
  output logic [WIDTH-1:0] st0_next
);
  import j4_pkg::*;

  always_comb begin
    st0_next = st0;
    case (insn_class(insn))
      cls_lit:  st0_next = WIDTH'(insn[14:0]);  // zero extended
      cls_zbr:  st0_next = st1;                 // flag popped
      cls_jmp,
      cls_call: st0_next = st0;
      cls_alu: begin
        case (insn[11:8])  // bit 12 unused
          op_t:     st0_next = st0;
          op_n:     st0_next = st1;
          op_add:   st0_next = st0 + st1;
          op_and:   st0_next = st0 & st1;
          op_or:    st0_next = st0 | st1;
          op_xor:   st0_next = st0 ^ st1;
          op_inv:   st0_next = ~st0;
          op_eq:    st0_next = {WIDTH{st1 == st0}};
          op_lt:    st0_next = {WIDTH{$signed(st1) < $signed(st0)}};
          op_sra:   st0_next = {st0[WIDTH-1], st0[WIDTH-1:1]};  // sign kept
          op_shl:   st0_next = {st0[WIDTH-2:0], 1'b0};
          op_r:     st0_next = rst0;
          op_mem:   st0_next = rd_data;
          op_io:    st0_next = rd_data;  // j4a picks io or ram word for us
          op_depth: st0_next = WIDTH'(dsp);
          op_ult:   st0_next = {WIDTH{st1 < st0}};
          default:  st0_next = st0;
        endcase
      end
      default: st0_next = st0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/stack2pipe4.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack2pipe4 #(
  parameter int  DEPTH   = 16,
  parameter type stack_t = logic [15:0]
) (
  input  logic          clk,
  input  j4_pkg::slot_t slot,   // slot executing this cycle
  input  logic          we,
  input  logic [1:0]    delta,  // signed step of the pointer
  input  stack_t        wd,
  output stack_t        rd      // top of next for the slot whose turn comes next
);
  import j4_pkg::*;

  localparam int ptr_w = $clog2(DEPTH);

  typedef logic [ptr_w-1:0] ptr_t;

  stack_t mem [num_slots][DEPTH];  // one circular stack per slot
  ptr_t   sp [num_slots];
  slot_t  slot_n;
  ptr_t   sp_next;

  // circular step, DEPTH need not be a power of two
  function automatic ptr_t step(ptr_t p, logic [1:0] d);
    int t;
    t = int'(p) + DEPTH + int'($signed(d));
    return ptr_t'(t % DEPTH);
  endfunction

  assign slot_n  = gray_next(slot);
  assign sp_next = step(sp[slot], delta);

  always_ff @(posedge clk) begin
    if (we)
      mem[slot][sp_next] <= wd;   // push lands on the new top
    sp[slot] <= sp_next;
    rd <= mem[slot_n][sp[slot_n]];  // other slot, untouched by this write
  end

endmodule

`default_nettype wire

// ==== hdl/j4.sv ====
`timescale 1ns/1ps
`default_nettype none

module j4 #(
  parameter int WIDTH = j4_pkg::word_width
) (
  input  logic             clk,
  input  logic             resetq,
  input  j4_pkg::insn_t    insn,          // code ram word, one cycle after code_addr
  output j4_pkg::pc_t      code_addr,
  input  logic [WIDTH-1:0] rd_data,       // io/ram word of the previous slot
  output logic [15:0]      mem_addr,
  output logic             mem_wr,
  output logic             io_wr,
  output logic             io_rd,
  output logic [WIDTH-1:0] dout,
  output j4_pkg::slot_t    io_slot,
  input  logic [3:0]       kill_slot_rq
);
  import j4_pkg::*;

  slot_t                slot;
  slot_t                slot_n;
  logic                 reboot;     // set one cycle ahead of the target slot
  logic [num_slots-1:0] kill_slot;  // pending kills, cleared on the slot's turn

  pc_t              pc;
  pc_t              pc_n;
  pc_t              pc_plus_1;
  pc_t              pc_d [3];  // round trip is 3 stages plus pc itself
  logic [4:0]       dsp;
  logic [4:0]       dsp_n;
  logic [4:0]       dsp_d [3];
  logic [WIDTH-1:0] st0;
  logic [WIDTH-1:0] st0_n;
  logic [WIDTH-1:0] alu_out;
  logic [WIDTH-1:0] st0_d [3];

  insn_t            insn_now;
  logic [WIDTH-1:0] rd_d [3];
  logic [WIDTH-1:0] st1;
  logic [15:0]      rst0;
  logic [15:0]      rstk_wd;

  logic       dstk_we;
  logic       rstk_we;
  logic       push_return_addr;
  logic [1:0] dsp_delta;
  logic [1:0] rsp_delta;
  logic [1:0] pc_sel;

  assign slot_n    = gray_next(slot);
  assign pc_plus_1 = pc + 13'd1;
  assign code_addr = pc_d[1];  // two turns ahead, insn_now adds the last cycle
  assign mem_addr  = 16'(st0);
  assign dout      = st1;
  assign io_slot   = slot;
  assign rstk_wd   = push_return_addr ? {2'b00, pc_plus_1, 1'b0} : 16'(st0);  // byte addr

  j4_decode decode (
    .insn(insn_now), .reboot(reboot), .st0_zero(st0 == '0),
    .dstk_we(dstk_we), .rstk_we(rstk_we),
    .dsp_delta(dsp_delta), .rsp_delta(rsp_delta),
    .pc_sel(pc_sel), .push_return_addr(push_return_addr),
    .mem_wr(mem_wr), .io_wr(io_wr), .io_rd(io_rd)
  );

  j4_alu #(.WIDTH(WIDTH)) alu (
    .insn(insn_now), .st0(st0), .st1(st1), .rst0(WIDTH'(rst0)),
    .rd_data(rd_d[2]), .dsp(dsp), .st0_next(alu_out)
  );

  stack2pipe4 #(.DEPTH(16), .stack_t(logic [WIDTH-1:0])) dstack (
    .clk(clk), .slot(slot), .we(dstk_we), .delta(dsp_delta), .wd(st0), .rd(st1)
  );

  stack2pipe4 #(.DEPTH(19), .stack_t(logic [15:0])) rstack (
    .clk(clk), .slot(slot), .we(rstk_we), .delta(rsp_delta), .wd(rstk_wd), .rd(rst0)
  );

  always_comb begin
    case (pc_sel)
      pc_sel_zero:   pc_n = '0;
      pc_sel_target: pc_n = insn_now[12:0];
      pc_sel_ret:    pc_n = rst0[13:1];  // rstack holds even byte addresses
      default:       pc_n = pc_plus_1;
    endcase
  end

  assign dsp_n = reboot ? 5'd0 : dsp + {{3{dsp_delta[1]}}, dsp_delta};  // empty after kill
  assign st0_n = reboot ? '0 : alu_out;

  // per-slot state waits here until its slot comes round
  always_ff @(posedge clk) begin
    insn_now <= insn;
    pc_d[0]  <= pc_n;
    pc_d[1]  <= pc_d[0];
    pc_d[2]  <= pc_d[1];
    dsp_d[0] <= dsp_n;
    dsp_d[1] <= dsp_d[0];
    dsp_d[2] <= dsp_d[1];
    st0_d[0] <= st0_n;
    st0_d[1] <= st0_d[0];
    st0_d[2] <= st0_d[1];
    rd_d[0]  <= rd_data;  // rd_data is one cycle behind its slot, so 3 more
    rd_d[1]  <= rd_d[0];
    rd_d[2]  <= rd_d[1];
  end

  always_ff @(posedge clk) begin
    if (!resetq) begin
      slot      <= '0;
      reboot    <= 1'b1;
      kill_slot <= '1;  // every slot comes up through a reboot turn
      pc        <= '0;
      dsp       <= '0;
      st0       <= '0;
    end else begin
      slot   <= slot_n;
      reboot <= kill_slot[slot_n] | kill_slot_rq[slot_n];  // look at the next slot
      for (int i = 0; i < num_slots; i++) begin
        if (kill_slot_rq[i])
          kill_slot[i] <= 1'b1;
        else if (slot == slot_t'(i))
          kill_slot[i] <= 1'b0;  // its reboot turn is this one
      end
      pc  <= pc_d[2];
      dsp <= dsp_d[2];
      st0 <= st0_d[2];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/j4a.sv ====
`timescale 1ns/1ps
`default_nettype none

module j4a #(
  parameter int WIDTH = j4_pkg::word_width
) (
  input  logic             clk,
  input  logic             resetq,
  input  logic             code_we,     // code load, used while reset is held
  input  j4_pkg::pc_t      code_waddr,
  input  j4_pkg::insn_t    code_wdata,
  input  logic [WIDTH-1:0] io_din,
  input  logic [3:0]       kill_slot_rq,
  output logic             io_wr,
  output logic             io_rd,
  output logic [15:0]      io_addr,
  output logic [WIDTH-1:0] io_dout,
  output j4_pkg::slot_t    io_slot
);
  import j4_pkg::*;

  localparam int code_words = 1 << $bits(pc_t);  // 8K
  localparam int data_words = 4096;              // byte addresses 0..8190

  insn_t            code_ram [code_words];
  logic [WIDTH-1:0] data_ram [data_words];

  insn_t            insn;
  pc_t              code_addr;
  logic [15:0]      mem_addr;
  logic             mem_wr;
  logic [WIDTH-1:0] dout;
  logic [WIDTH-1:0] mem_q;    // ram word at st0 of last cycle
  logic [WIDTH-1:0] io_q;
  logic             io_sel;   // last cycle was an io read
  logic [WIDTH-1:0] rd_data;

  assign io_addr = mem_addr;  // io and data ram share the st0 address
  assign io_dout = dout;

  always_ff @(posedge clk) begin
    if (code_we)
      code_ram[code_waddr] <= code_wdata;
    insn <= code_ram[code_addr];  // registered read
  end

  always_ff @(posedge clk) begin
    if (mem_wr)
      data_ram[mem_addr[12:1]] <= dout;
    mem_q <= data_ram[mem_addr[12:1]];
    io_q  <= io_din;
  end

  always_ff @(posedge clk) begin
    if (!resetq)
      io_sel <= 1'b0;
    else
      io_sel <= io_rd;
  end

  assign rd_data = io_sel ? io_q : mem_q;

  j4 #(.WIDTH(WIDTH)) core (
    .clk(clk), .resetq(resetq),
    .insn(insn), .code_addr(code_addr),
    .rd_data(rd_data), .mem_addr(mem_addr), .mem_wr(mem_wr),
    .io_wr(io_wr), .io_rd(io_rd), .dout(dout), .io_slot(io_slot),
    .kill_slot_rq(kill_slot_rq)
  );

endmodule

`default_nettype wire

// ==== test/j4a_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module j4a_tb;
  import j4_pkg::*;

  logic        clk, resetq, code_we, io_wr, io_rd;
  pc_t         code_waddr;
  insn_t       code_wdata;
  logic [15:0] io_din, io_addr, io_dout;
  logic [3:0]  kill_slot_rq;
  slot_t       io_slot;

  insn_t       code [8192];        // image loaded into the code ram
  logic [15:0] dram [4096];        // model copy of the data ram
  logic [15:0] io_val [4];         // io_din seen by each slot
  logic [15:0] exp_a [4][512];     // expected io_addr per slot, in order
  logic [15:0] exp_d [4][512];
  logic [15:0] exp_ra [4][64];     // expected io_addr of each io read
  int          exp_n [4], pos [4], base [4], kind [4];
  int          exp_rn [4], rpos [4];
  int          cur, top, gdsp, errors, checks, tests, failed;

  j4a #(.WIDTH(16)) DUT (
    .clk(clk), .resetq(resetq), .code_we(code_we), .code_waddr(code_waddr),
    .code_wdata(code_wdata), .io_din(io_din), .kill_slot_rq(kill_slot_rq),
    .io_wr(io_wr), .io_rd(io_rd), .io_addr(io_addr), .io_dout(io_dout), .io_slot(io_slot)
  );

  always #5 clk = ~clk;

  // slots run 00 01 11 10, so drive the value of the slot coming up
  always @(posedge clk) io_din <= io_val[{io_slot[0], ~io_slot[1]}];

  task automatic put(input insn_t w);
    code[cur] = w;
    cur++;
    if (cur > top) top = cur;
  endtask

  task automatic lit(input logic [15:0] v);
    put({1'b1, v[14:0]});
    gdsp++;
  endtask

  task automatic alu(input logic [3:0] op, input logic [2:0] fn, input logic [1:0] rd,
                     input logic [1:0] dd, input logic ret);
    put({3'b011, 1'b0, op, ret, fn, rd, dd});
    gdsp += int'($signed(dd));
  endtask

  task automatic drop();
    alu(op_n, 3'd0, 2'b00, 2'b11, 1'b0);
  endtask

  task automatic out();  // io write of st0 to a random port, st0 kept
    lit(16'($urandom));
    alu(op_n, fn_io_w, 2'b00, 2'b11, 1'b0);
  endtask

  task automatic push_rand();
    lit(16'($urandom));
    if ($urandom % 2) alu(op_inv, 3'd0, 2'b00, 2'b00, 1'b0);  // reach the top bit
  endtask

  task automatic gen_op(input logic [3:0] op, input int s);
    case (op)
      op_t, op_inv, op_sra, op_shl, op_depth: begin
        push_rand();
        alu(op, 3'd0, 2'b00, 2'b00, 1'b0);
      end
      op_r: begin
        push_rand();
        push_rand();
        alu(op_n, fn_t_r, 2'b01, 2'b11, 1'b0);  // T to R
        alu(op_r, 3'd0, 2'b11, 2'b00, 1'b0);
      end
      op_mem: begin
        lit(16'($urandom));
        lit(16'(2 * (256 * (s + 1) + $urandom % 256)));  // own region per slot
        alu(op_t, fn_mem_w, 2'b00, 2'b00, 1'b0);
        alu(op_t, 3'd0, 2'b00, 2'b00, 1'b0);  // address held one more turn
        alu(op_mem, 3'd0, 2'b00, 2'b00, 1'b0);
      end
      op_io: begin
        alu(op_t, fn_io_r, 2'b00, 2'b00, 1'b0);
        alu(op_io, fn_t_n, 2'b00, 2'b01, 1'b0);
      end
      default: begin
        push_rand();
        push_rand();
        alu(op, 3'd0, 2'b00, 2'b11, 1'b0);
      end
    endcase
    out();
    while (gdsp > 0) drop();
  endtask

  task automatic gen_stack();
    int n;
    n = 3 + $urandom % 4;
    repeat (n) lit(16'($urandom));
    repeat (8) begin
      case ($urandom % 4)
        0: if (gdsp < 12) alu(op_t, fn_t_n, 2'b00, 2'b01, 1'b0);               // dup
        1: if (gdsp >= 2) alu(op_n, fn_t_n, 2'b00, 2'b00, 1'b0);               // swap
        2: if (gdsp >= 2) drop();
        default: if (gdsp >= 2 && gdsp < 12) alu(op_n, fn_t_n, 2'b00, 2'b01, 1'b0);  // over
      endcase
    end
    while (gdsp > 0) begin
      out();
      drop();
    end
  endtask

  task automatic gen_flow();
    int p, q, sub;
    repeat (6) begin
      p = cur;
      case ($urandom % 3)
        0: begin
          put('0);
          lit(16'h1111);  // skipped by the jump
          out();
          drop();
          code[p] = {cls_jmp, pc_t'(cur)};
        end
        1: begin
          put('0);
          q = cur;
          put('0);
          sub = cur;
          lit(16'($urandom));
          out();
          drop();
          alu(op_t, 3'd0, 2'b11, 2'b00, 1'b1);  // return
          code[p] = {cls_call, pc_t'(sub)};
          code[q] = {cls_jmp, pc_t'(cur)};
        end
        default: begin
          lit(16'($urandom % 2));
          p = cur;
          put('0);
          gdsp--;  // 0branch pops the flag
          lit(16'($urandom));
          out();
          drop();
          code[p] = {cls_zbr, pc_t'(cur)};
        end
      endcase
      lit(16'($urandom));  // marker after each construct
      out();
      drop();
    end
  endtask

  task automatic build();
    for (int a = 0; a < 8192; a++) code[a] = {cls_jmp, pc_t'(a)};  // self jump everywhere
    cur = 0;
    top = 0;
    put({cls_jmp, 13'd1});
    alu(op_t, fn_io_r, 2'b00, 2'b00, 1'b0);   // dispatch on the slot's io value
    alu(op_io, fn_t_n, 2'b00, 2'b01, 1'b0);
    alu(op_n, fn_t_r, 2'b01, 2'b11, 1'b0);
    alu(op_t, 3'd0, 2'b11, 2'b00, 1'b1);
    for (int s = 0; s < 4; s++) begin
      cur = base[s];
      gdsp = 0;
      case (kind[s])
        1: for (int op = 0; op < 16; op++) gen_op(4'(op), s);
        2: gen_stack();
        3: gen_flow();
        default: repeat (4) begin
          gen_op(op_mem, s);
          gen_op(op_io, s);
        end
      endcase
      put({cls_jmp, pc_t'(cur)});
    end
  endtask

  // instruction-set model of one thread, collects its io writes and reads
  task automatic model(input int s);
    pc_t         pc;
    insn_t       w;
    logic [15:0] st0, st1, r0, res, nrd, rdv;
    logic [15:0] ds [16];
    logic [15:0] rs [19];
    logic [4:0]  dsp;
    int          dp, rp, n;
    pc = '0;
    st0 = '0;
    rdv = '0;
    dsp = '0;
    dp = 0;
    rp = 0;
    exp_n[s] = 0;
    exp_rn[s] = 0;
    for (int i = 0; i < 19; i++) rs[i] = '0;
    for (int i = 0; i < 16; i++) ds[i] = '0;
    for (n = 0; n < 4000; n++) begin
      w = code[pc];
      st1 = ds[dp];
      r0 = rs[rp];
      nrd = (w[15:13] == cls_alu && w[6:4] == fn_io_r) ? io_val[s] : dram[st0[12:1]];
      if (w[15]) begin
        dp = (dp + 1) % 16;
        ds[dp] = st0;
        st0 = {1'b0, w[14:0]};
        dsp++;
        pc++;
      end else if (w[14:13] == 2'b00) begin
        if (w[12:0] == pc) break;  // program end
        pc = w[12:0];
      end else if (w[14:13] == 2'b01) begin
        pc = (st0 == '0) ? w[12:0] : pc + 13'd1;
        st0 = st1;
        dp = (dp + 15) % 16;
        dsp--;
      end else if (w[14:13] == 2'b10) begin
        rp = (rp + 1) % 19;
        rs[rp] = {2'b00, pc + 13'd1, 1'b0};  // byte address of the return
        pc = w[12:0];
      end else begin
        case (w[11:8])
          op_t:     res = st0;
          op_n:     res = st1;
          op_add:   res = st0 + st1;
          op_and:   res = st0 & st1;
          op_or:    res = st0 | st1;
          op_xor:   res = st0 ^ st1;
          op_inv:   res = ~st0;
          op_eq:    res = (st1 == st0) ? 16'hffff : 16'h0;
          op_lt:    res = ($signed(st1) < $signed(st0)) ? 16'hffff : 16'h0;
          op_sra:   res = {st0[15], st0[15:1]};
          op_shl:   res = {st0[14:0], 1'b0};
          op_r:     res = r0;
          op_depth: res = {11'd0, dsp};
          op_ult:   res = (st1 < st0) ? 16'hffff : 16'h0;
          default:  res = rdv;  // memory or io word from the last turn
        endcase
        if (w[6:4] == fn_io_w && exp_n[s] < 512) begin
          exp_a[s][exp_n[s]] = st0;
          exp_d[s][exp_n[s]] = st1;
          exp_n[s]++;
        end
        if (w[6:4] == fn_io_r && exp_rn[s] < 64) begin
          exp_ra[s][exp_rn[s]] = st0;  // io read strobes the st0 port
          exp_rn[s]++;
        end
        if (w[6:4] == fn_mem_w) dram[st0[12:1]] = st1;
        dp = (dp + 16 + int'($signed(w[1:0]))) % 16;
        if (w[6:4] == fn_t_n) ds[dp] = st0;
        rp = (rp + 19 + int'($signed(w[3:2]))) % 19;
        if (w[6:4] == fn_t_r) rs[rp] = st0;
        dsp = dsp + {{3{w[1]}}, w[1:0]};
        pc = w[7] ? r0[13:1] : pc + 13'd1;
        st0 = res;
      end
      rdv = nrd;
    end
  endtask

  task automatic check_write();
    int s;
    s = int'(io_slot);
    if (pos[s] >= exp_n[s]) begin
      errors++;
      $display("slot %0d made an io write after its program was done, at %0t", s, $time);
    end else begin
      checks++;
      if (io_addr !== exp_a[s][pos[s]]) begin
        errors++;
        $display("error at %0t: io_addr slot %0d got %h expected %h",
                 $time, s, io_addr, exp_a[s][pos[s]]);
      end
      if (io_dout !== exp_d[s][pos[s]]) begin
        errors++;
        $display("error at %0t: io_dout slot %0d got %h expected %h",
                 $time, s, io_dout, exp_d[s][pos[s]]);
      end
      pos[s]++;
    end
  endtask

  task automatic check_read();
    int s;
    s = int'(io_slot);
    if (rpos[s] >= exp_rn[s]) begin
      errors++;
      $display("slot %0d made an io read its program does not have, at %0t", s, $time);
    end else begin
      checks++;
      if (io_addr !== exp_ra[s][rpos[s]]) begin
        errors++;
        $display("error at %0t: io_addr on read slot %0d got %h expected %h",
                 $time, s, io_addr, exp_ra[s][rpos[s]]);
      end
      rpos[s]++;
    end
  endtask

  task automatic run_test(input string name, input logic kill_en);
    int   e0, cyc, extra, k, total;
    logic killed, pulse_on, done;
    e0 = errors;
    build();
    total = 0;
    for (int s = 0; s < 4; s++) begin
      model(s);
      pos[s] = 0;
      rpos[s] = 0;
      total += exp_n[s];
    end
    k = $urandom % 4;
    @(posedge clk);
    resetq <= 1'b0;
    for (int a = 0; a <= top; a++) begin
      @(posedge clk);
      code_we    <= 1'b1;
      code_waddr <= pc_t'(a);
      code_wdata <= code[a];
    end
    @(posedge clk);
    code_we <= 1'b0;
    repeat (8) @(posedge clk);
    resetq <= 1'b1;
    killed = 1'b0;
    pulse_on = 1'b0;
    cyc = 0;
    extra = 0;
    while (extra < 40 && cyc < 30000) begin  // extra cycles catch stray writes
      @(posedge clk);
      cyc++;
      if (io_wr) check_write();
      if (io_rd) check_read();
      if (pulse_on) begin
        kill_slot_rq <= 4'b0;
        total += pos[k];  // writes made before the kill come again
        pos[k] = 0;       // killed slot replays from the start
        rpos[k] = 0;
        pulse_on = 1'b0;
      end else if (kill_en && !killed && pos[k] >= 2) begin
        kill_slot_rq <= 4'b1 << k;
        killed = 1'b1;
        pulse_on = 1'b1;
      end
      done = !pulse_on && (killed || !kill_en);
      for (int s = 0; s < 4; s++)
        if (pos[s] < exp_n[s] || rpos[s] < exp_rn[s]) done = 1'b0;
      if (done) extra++;
    end
    if (cyc >= 30000) begin
      errors++;
      $display("test %s timed out waiting for io writes", name);
    end
    tests++;
    if (errors == e0) begin
      $display("test %s: ok, %0d io writes", name, total);
    end else begin
      failed++;
      $display("test %s: FAILED, %0d errors", name, errors - e0);
    end
  endtask

  initial begin
    clk = 1'b0;
    resetq = 1'b0;
    code_we = 1'b0;
    code_waddr = '0;
    code_wdata = '0;
    io_din = '0;
    kill_slot_rq = '0;
    errors = 0;
    checks = 0;
    tests = 0;
    failed = 0;
    void'($urandom(32'h55db35d8));
    for (int s = 0; s < 4; s++) begin
      base[s] = 64 + 1024 * s;
      io_val[s] = 16'(2 * base[s]);  // byte address of the slot routine
    end
    kind = '{1, 1, 1, 1};
    run_test("alu ops", 1'b0);
    kind = '{2, 2, 2, 2};
    run_test("stack", 1'b0);
    kind = '{3, 3, 3, 3};
    run_test("control flow", 1'b0);
    kind = '{4, 4, 4, 4};
    run_test("memory and io", 1'b0);
    kind = '{1, 2, 3, 4};
    run_test("thread isolation", 1'b0);
    run_test("kill", 1'b1);
    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== j4a.f ====
hdl/j4_pkg.sv
hdl/j4_decode.sv
hdl/j4_alu.sv
hdl/stack2pipe4.sv
hdl/j4.sv
hdl/j4a.sv
test/j4a_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the j4a testbench, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module j4a_tb -f j4a.f -o j4a_sim \
  && ./obj_dir/j4a_sim | tee /dev/stderr | grep -qx "Verification passed" \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }
